// ==== source/cpu_consts.svh ====
// CPU widths, data memory size and opcode values
// Operand select, ALU function and flag bit codes
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define DATA_W     8   // Data word
`define ADDR_W     8   // PC and ROM address
`define OPC_W      7   // Opcode field
`define INSTR_W    15  // Opcode plus 8-bit immediate
`define DMEM_DEPTH 32  // Data memory words
`define DMEM_AW    5   // Low address bits used as index

// Opcodes
`define OP_NOP     7'h00
`define OP_LDA     7'h01
`define OP_LDB     7'h02
`define OP_LDAB    7'h03
`define OP_ADD     7'h04
`define OP_SUB     7'h06
`define OP_AND     7'h08
`define OP_OR      7'h0A
`define OP_NOT     7'h0C
`define OP_XOR     7'h0E
`define OP_SHL     7'h10
`define OP_SHR     7'h12
`define OP_STORE   7'h14
`define OP_LOAD    7'h16
`define OP_LDA_IMM 7'h18 // A = 0 + imm
`define OP_LDB_IMM 7'h1A // B = 0 + imm
`define OP_JMP     7'h40
`define OP_JZ      7'h41
`define OP_JNZ     7'h42
`define OP_JN      7'h43
`define OP_JC      7'h44

// Operand A mux
`define SEL_A_A    2'd0
`define SEL_A_ONE  2'd1
`define SEL_A_ZERO 2'd2
`define SEL_A_B    2'd3

// Operand B mux
`define SEL_B_B    2'd0
`define SEL_B_MEM  2'd1
`define SEL_B_IMM  2'd2
`define SEL_B_ZERO 2'd3

// ALU functions
`define ALU_ADD    3'd0
`define ALU_SUB    3'd1
`define ALU_AND    3'd2
`define ALU_OR     3'd3
`define ALU_NOT    3'd4
`define ALU_XOR    3'd5
`define ALU_SHL    3'd6
`define ALU_SHR    3'd7

// Bit positions in the status word
`define FLAG_Z     3
`define FLAG_N     2
`define FLAG_C     1
`define FLAG_V     0

`endif

// ==== source/cpu_pkg.sv ====
// CPU core types
// Data, address, instruction, control field and flag vectors
`default_nettype none

package cpu_pkg;

`include "cpu_consts.svh"

    typedef logic [`DATA_W-1:0]  data_t;     // Register and memory word
    typedef logic [`ADDR_W-1:0]  addr_t;     // Program address
    typedef logic [`INSTR_W-1:0] instr_t;    // {opcode, imm}
    typedef logic [`OPC_W-1:0]   opcode_t;

    // 0 add, 1 sub, 2 and, 3 or, 4 not, 5 xor, 6 shl, 7 shr
    typedef logic [2:0]          alu_op_t;

    // {Z, N, C, V}
    typedef logic [3:0]          flags_t;

    typedef logic [1:0]          sel_t;      // Operand mux select
    typedef logic [`DMEM_AW-1:0] dmem_idx_t; // Data memory index

endpackage

`default_nettype wire

// ==== source/disp_pkg.sv ====
// Display types and view mode enum
`default_nettype none

package disp_pkg;

    typedef logic [3:0] nibble_t; // LED view value
    typedef logic [6:0] seg_t;    // Active low, A in MSB down to G

    // View order on mode button
    typedef enum logic [1:0] {
        MODE_PC  = 2'd0,
        MODE_A   = 2'd1,
        MODE_B   = 2'd2,
        MODE_ALU = 2'd3
    } disp_mode_t;

endpackage

`default_nettype wire

// ==== source/cpu_if.sv ====
// ctrl_if between decoder and datapath
// view_if from datapath to display
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if import cpu_pkg::*; (
    input logic CLK,
    input logic rst
);
    logic    load_pc;     // Take imm as next PC
    logic    mem_write;
    logic    addr_from_b; // Memory address from B instead of imm
    logic    load_a;
    logic    load_b;
    sel_t    sel_a;
    sel_t    sel_b;
    alu_op_t alu_op;
    opcode_t opcode;      // From current instruction
    flags_t  flags;       // Status register

    modport decoder (
        input  CLK, rst, opcode, flags,
        output load_pc, mem_write, addr_from_b, load_a, load_b, sel_a, sel_b, alu_op
    );

    modport path (
        input  load_pc, mem_write, addr_from_b, load_a, load_b, sel_a, sel_b, alu_op,
        output opcode, flags
    );
endinterface

interface view_if import cpu_pkg::*; ();
    addr_t pc;
    data_t reg_a;
    data_t reg_b;
    data_t alu_out; // Live ALU result

    modport src  (output pc, reg_a, reg_b, alu_out);
    modport sink (input  pc, reg_a, reg_b, alu_out);
endinterface

`default_nettype wire

// ==== source/program_rom.sv ====
// Fixed program ROM, combinational read
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module program_rom import cpu_pkg::*; (
    input  addr_t  i_addr,
    output instr_t o_instr
);

    always_comb begin
        case (i_addr)
            8'd0:  o_instr = {`OP_LDA_IMM, 8'h05}; // A = 05
            8'd1:  o_instr = {`OP_LDB_IMM, 8'h03}; // B = 03
            8'd2:  o_instr = {`OP_ADD,     8'h00}; // A = 08
            8'd3:  o_instr = {`OP_SUB,     8'h00}; // A = 05
            8'd4:  o_instr = {`OP_AND,     8'h00}; // A = 01
            8'd5:  o_instr = {`OP_OR,      8'h00}; // A = 03
            8'd6:  o_instr = {`OP_XOR,     8'h00}; // A = 00, Z set
            8'd7:  o_instr = {`OP_JZ,      8'h09}; // Taken
            8'd8:  o_instr = {`OP_LDA_IMM, 8'h0F}; // Skipped
            8'd9:  o_instr = {`OP_JZ,      8'h00}; // Not taken, flags of 0+3
            8'd10: o_instr = {`OP_JC,      8'h00}; // Not taken
            8'd11: o_instr = {`OP_NOT,     8'h00}; // A = FF
            8'd12: o_instr = {`OP_SHL,     8'h00}; // A = FE, C from FF+03
            8'd13: o_instr = {`OP_JC,      8'h0F}; // Taken
            8'd14: o_instr = {`OP_LDB_IMM, 8'h0F}; // Skipped
            8'd15: o_instr = {`OP_SHR,     8'h00}; // A = 7F
            8'd16: o_instr = {`OP_STORE,   8'h04}; // mem[4] = 7F+03 = 82
            8'd17: o_instr = {`OP_LDA_IMM, 8'h00}; // Clear A before load
            8'd18: o_instr = {`OP_LOAD,    8'h04}; // A = 0 + mem[4] = 82
            8'd19: o_instr = {`OP_JMP,     8'h00}; // Loop
            default: o_instr = {`OP_NOP,   8'h00};
        endcase
    end

endmodule

`default_nettype wire

// ==== source/control_decoder.sv ====
// Control decoder, opcode and status flags to control signals
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module control_decoder import cpu_pkg::*; (
    ctrl_if.decoder ctrl
);

    always_comb begin
        // Idle word, A+B through the ALU with nothing loaded
        ctrl.load_pc     = 1'b0;
        ctrl.mem_write   = 1'b0;
        ctrl.addr_from_b = 1'b0;
        ctrl.load_a      = 1'b0;
        ctrl.load_b      = 1'b0;
        ctrl.sel_a       = `SEL_A_A;
        ctrl.sel_b       = `SEL_B_B;
        ctrl.alu_op      = `ALU_ADD;

        case (ctrl.opcode)
            `OP_LDA:  ctrl.load_a = 1'b1;
            `OP_LDB:  ctrl.load_b = 1'b1;
            `OP_LDAB: begin
                ctrl.load_a = 1'b1;
                ctrl.load_b = 1'b1;
            end
            `OP_ADD:  ctrl.load_a = 1'b1;
            `OP_SUB:  begin
                ctrl.load_a = 1'b1;
                ctrl.alu_op = `ALU_SUB;
            end
            `OP_AND:  begin
                ctrl.load_a = 1'b1;
                ctrl.alu_op = `ALU_AND;
            end
            `OP_OR:   begin
                ctrl.load_a = 1'b1;
                ctrl.alu_op = `ALU_OR;
            end
            `OP_NOT:  begin
                ctrl.load_a = 1'b1;
                ctrl.alu_op = `ALU_NOT;
            end
            `OP_XOR:  begin
                ctrl.load_a = 1'b1;
                ctrl.alu_op = `ALU_XOR;
            end
            `OP_SHL:  begin
                ctrl.load_a = 1'b1;
                ctrl.alu_op = `ALU_SHL;
            end
            `OP_SHR:  begin
                ctrl.load_a = 1'b1;
                ctrl.alu_op = `ALU_SHR;
            end
            `OP_STORE: ctrl.mem_write = 1'b1; // A+B to mem[imm]
            `OP_LOAD:  begin
                ctrl.load_a = 1'b1;
                ctrl.sel_b  = `SEL_B_MEM;     // A + mem[imm]
            end
            `OP_LDA_IMM: begin
                ctrl.load_a = 1'b1;
                ctrl.sel_a  = `SEL_A_ZERO;
                ctrl.sel_b  = `SEL_B_IMM;
            end
            `OP_LDB_IMM: begin
                ctrl.load_b = 1'b1;
                ctrl.sel_a  = `SEL_A_ZERO;
                ctrl.sel_b  = `SEL_B_IMM;
            end
            // Conditions read the status register, i.e. last step's flags
            `OP_JMP: ctrl.load_pc = 1'b1;
            `OP_JZ:  ctrl.load_pc = ctrl.flags[`FLAG_Z];
            `OP_JNZ: ctrl.load_pc = ~ctrl.flags[`FLAG_Z];
            `OP_JN:  ctrl.load_pc = ctrl.flags[`FLAG_N];
            `OP_JC:  ctrl.load_pc = ctrl.flags[`FLAG_C];
            default: ; // NOP and unknown codes
        endcase
    end

    // A store never also writes a register at the same step
    a_store_excl: assert property (@(posedge ctrl.CLK) disable iff (ctrl.rst)
        ctrl.mem_write |-> !(ctrl.load_a || ctrl.load_b));

endmodule

`default_nettype wire

// ==== source/alu.sv ====
// Eight-function ALU with Z/N/C/V flags
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module alu import cpu_pkg::*; (
    input  data_t   i_a,
    input  data_t   i_b,
    input  alu_op_t i_op,
    output data_t   o_result,
    output flags_t  o_flags
);

    logic [`DATA_W:0] sum9;   // Carry out in MSB
    logic [`DATA_W:0] diff9;  // Borrow in MSB
    logic [`DATA_W:0] carry9;
    data_t            result;

    assign sum9   = {1'b0, i_a} + {1'b0, i_b};
    assign diff9  = {1'b0, i_a} - {1'b0, i_b};
    assign carry9 = (i_op == `ALU_SUB) ? diff9 : sum9; // Sub borrows, rest use the sum

    always_comb begin
        case (i_op)
            `ALU_ADD: result = sum9[`DATA_W-1:0];
            `ALU_SUB: result = diff9[`DATA_W-1:0];
            `ALU_AND: result = i_a & i_b;
            `ALU_OR:  result = i_a | i_b;
            `ALU_NOT: result = ~i_a;        // B ignored
            `ALU_XOR: result = i_a ^ i_b;
            `ALU_SHL: result = i_a << 1;
            default:  result = i_a >> 1;    // SHR, zero fill
        endcase
    end

    assign o_result          = result;
    assign o_flags[`FLAG_Z]  = (result == '0);
    assign o_flags[`FLAG_N]  = result[`DATA_W-1];
    assign o_flags[`FLAG_C]  = carry9[`DATA_W];
    // Same-sign inputs, result sign flipped
    assign o_flags[`FLAG_V]  = (i_a[`DATA_W-1] == i_b[`DATA_W-1]) &&
                               (result[`DATA_W-1] != i_a[`DATA_W-1]);

endmodule

`default_nettype wire

// ==== source/datapath.sv ====
// Datapath with PC, A, B, status register, data memory and operand muxes
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module datapath import cpu_pkg::*; (
    input  logic   CLK,
    input  logic   rst,
    input  logic   i_step,
    input  instr_t i_instr,
    output addr_t  o_pc,
    ctrl_if.path   ctrl,
    view_if.src    view
);

    addr_t     r_pc;
    data_t     r_a;
    data_t     r_b;
    flags_t    r_flags;
    data_t     mem [0:`DMEM_DEPTH-1];
    data_t     imm;
    data_t     opnd_a;
    data_t     opnd_b;
    data_t     mem_addr;
    dmem_idx_t mem_idx;
    data_t     mem_rd;
    data_t     alu_res;
    flags_t    alu_flags;

    assign imm         = i_instr[`DATA_W-1:0];
    assign ctrl.opcode = i_instr[`INSTR_W-1:`DATA_W];
    assign ctrl.flags  = r_flags;

    // Memory address, low bits only
    assign mem_addr = ctrl.addr_from_b ? r_b : imm;
    assign mem_idx  = mem_addr[`DMEM_AW-1:0];
    assign mem_rd   = mem[mem_idx]; // Async read

    always_comb begin
        case (ctrl.sel_a)
            `SEL_A_A:    opnd_a = r_a;
            `SEL_A_ONE:  opnd_a = data_t'(1);
            `SEL_A_ZERO: opnd_a = '0;
            default:     opnd_a = r_b;
        endcase
        case (ctrl.sel_b)
            `SEL_B_B:    opnd_b = r_b;
            `SEL_B_MEM:  opnd_b = mem_rd;
            `SEL_B_IMM:  opnd_b = imm;
            default:     opnd_b = '0;
        endcase
    end

    alu u_alu (
        .i_a      (opnd_a),
        .i_b      (opnd_b),
        .i_op     (ctrl.alu_op),
        .o_result (alu_res),
        .o_flags  (alu_flags)
    );

    // One instruction per step
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            r_pc    <= '0;
            r_a     <= '0;
            r_b     <= '0;
            r_flags <= '0;
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (i_step) begin
            r_pc    <= ctrl.load_pc ? imm : r_pc + addr_t'(1);
            r_flags <= alu_flags; // Every step, jumps included
            if (ctrl.load_a) r_a <= alu_res;
            if (ctrl.load_b) r_b <= alu_res;
            if (ctrl.mem_write) mem[mem_idx] <= alu_res;
        end
    end

    assign o_pc         = r_pc;
    assign view.pc      = r_pc;
    assign view.reg_a   = r_a;
    assign view.reg_b   = r_b;
    assign view.alu_out = alu_res;

    // PC holds across any edge without a step
    a_pc_on_step: assert property (@(posedge CLK) disable iff (rst)
        !$past(i_step) |-> $stable(r_pc));

endmodule

`default_nettype wire

// ==== source/display_unit.sv ====
// Display unit with view mode FSM, nibble select, decimal split, segment decode
`timescale 1ns/1ps
`default_nettype none

module display_unit import disp_pkg::*; (
    input  logic    CLK,
    input  logic    rst,
    input  logic    i_mode_next,
    view_if.sink    view,
    output nibble_t o_led,
    output seg_t    o_seg_tens,
    output seg_t    o_seg_ones
);

    disp_mode_t r_mode;
    disp_mode_t next_mode;
    nibble_t    view_nib;
    nibble_t    tens;
    nibble_t    ones;

    // Active-low digit patterns, blank past 9
    function automatic seg_t digit_seg(input nibble_t d);
        case (d)
            4'd0:    digit_seg = 7'b0000001;
            4'd1:    digit_seg = 7'b1001111;
            4'd2:    digit_seg = 7'b0010010;
            4'd3:    digit_seg = 7'b0000110;
            4'd4:    digit_seg = 7'b1001100;
            4'd5:    digit_seg = 7'b0100100;
            4'd6:    digit_seg = 7'b0100000;
            4'd7:    digit_seg = 7'b0001111;
            4'd8:    digit_seg = 7'b0000000;
            4'd9:    digit_seg = 7'b0000100;
            default: digit_seg = 7'b1111111;
        endcase
    endfunction

    always_comb begin
        case (r_mode) // PC, A, B, ALU, wrap
            MODE_PC: next_mode = MODE_A;
            MODE_A:  next_mode = MODE_B;
            MODE_B:  next_mode = MODE_ALU;
            default: next_mode = MODE_PC;
        endcase
    end

    always_ff @(posedge CLK or posedge rst) begin
        if (rst) r_mode <= MODE_PC;
        else if (i_mode_next) r_mode <= next_mode;
    end

    always_comb begin
        case (r_mode)
            MODE_PC: view_nib = view.pc[3:0];
            MODE_A:  view_nib = view.reg_a[3:0];
            MODE_B:  view_nib = view.reg_b[3:0];
            default: view_nib = view.alu_out[3:0];
        endcase
        // 0..15 as two decimal digits
        if (view_nib >= 4'd10) begin
            tens = 4'd1;
            ones = view_nib - 4'd10;
        end else begin
            tens = 4'd0;
            ones = view_nib;
        end
    end

    assign o_led      = view_nib; // MSB on leftmost LED
    assign o_seg_tens = digit_seg(tens);
    assign o_seg_ones = digit_seg(ones);

    a_ones_digit: assert property (@(posedge CLK) disable iff (rst) ones <= 4'd9);

endmodule

`default_nettype wire

// ==== source/cpu_board_top.sv ====
// Top level, ROM, decoder, datapath and display wired together
`timescale 1ns/1ps
`default_nettype none

module cpu_board_top import cpu_pkg::*, disp_pkg::*; (
    input  logic    CLK,
    input  logic    rst,
    input  logic    i_step,       // Execute one instruction
    input  logic    i_mode_next,  // Advance display view
    output nibble_t o_led,
    output seg_t    o_seg_tens,
    output seg_t    o_seg_ones
);

    addr_t  pc;
    instr_t instr;

    ctrl_if u_ctrl_if (.CLK(CLK), .rst(rst));
    view_if u_view_if ();

    program_rom u_rom (
        .i_addr  (pc),
        .o_instr (instr)
    );

    control_decoder u_dec (
        .ctrl (u_ctrl_if.decoder)
    );

    datapath u_dp (
        .CLK     (CLK),
        .rst     (rst),
        .i_step  (i_step),
        .i_instr (instr),
        .o_pc    (pc),
        .ctrl    (u_ctrl_if.path),
        .view    (u_view_if.src)
    );

    display_unit u_disp (
        .CLK         (CLK),
        .rst         (rst),
        .i_mode_next (i_mode_next),
        .view        (u_view_if.sink),
        .o_led       (o_led),
        .o_seg_tens  (o_seg_tens),
        .o_seg_ones  (o_seg_ones)
    );

endmodule

`default_nettype wire

// ==== tests/cpu_model.svh ====
// Reference model of the ISA with program image and register state
// Expected LED nibble and seven-segment digit patterns
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

addr_t      ref_pc;
data_t      ref_a;
data_t      ref_b;
flags_t     ref_flags;                 // {Z, N, C, V} of the last step
data_t      ref_mem [0:`DMEM_DEPTH-1];
disp_mode_t ref_mode;

// Program image, NOP past the end
function automatic instr_t rom_word(input addr_t a);
    case (a)
        8'd0:    return {`OP_LDA_IMM, 8'h05};
        8'd1:    return {`OP_LDB_IMM, 8'h03};
        8'd2:    return {`OP_ADD,     8'h00};
        8'd3:    return {`OP_SUB,     8'h00};
        8'd4:    return {`OP_AND,     8'h00};
        8'd5:    return {`OP_OR,      8'h00};
        8'd6:    return {`OP_XOR,     8'h00};
        8'd7:    return {`OP_JZ,      8'h09};
        8'd8:    return {`OP_LDA_IMM, 8'h0F};
        8'd9:    return {`OP_JZ,      8'h00};
        8'd10:   return {`OP_JC,      8'h00};
        8'd11:   return {`OP_NOT,     8'h00};
        8'd12:   return {`OP_SHL,     8'h00};
        8'd13:   return {`OP_JC,      8'h0F};
        8'd14:   return {`OP_LDB_IMM, 8'h0F};
        8'd15:   return {`OP_SHR,     8'h00};
        8'd16:   return {`OP_STORE,   8'h04};
        8'd17:   return {`OP_LDA_IMM, 8'h00};
        8'd18:   return {`OP_LOAD,    8'h04};
        8'd19:   return {`OP_JMP,     8'h00};
        default: return {`OP_NOP,     8'h00};
    endcase
endfunction

// Active-low patterns, A in the MSB
function automatic seg_t digit_pattern(input nibble_t d);
    case (d)
        4'd0:    return 7'b0000001;
        4'd1:    return 7'b1001111;
        4'd2:    return 7'b0010010;
        4'd3:    return 7'b0000110;
        4'd4:    return 7'b1001100;
        4'd5:    return 7'b0100100;
        4'd6:    return 7'b0100000;
        4'd7:    return 7'b0001111;
        4'd8:    return 7'b0000000;
        4'd9:    return 7'b0000100;
        default: return 7'b1111111;
    endcase
endfunction

// Result, flags and effects of the instruction at ref_pc
function automatic void eval_instr(output data_t res, output flags_t flg,
                                   output data_t imm, output logic wr_a,
                                   output logic wr_b, output logic wr_mem,
                                   output logic jump);
    instr_t           ins;
    opcode_t          opc;
    data_t            x;
    data_t            y;
    logic [`DATA_W:0] wide; // Carry or borrow on top
    ins    = rom_word(ref_pc);
    opc    = ins[`INSTR_W-1:`DATA_W];
    imm    = ins[`DATA_W-1:0];
    x      = ref_a;
    y      = ref_b;
    wr_a   = 1'b0;
    wr_b   = 1'b0;
    wr_mem = 1'b0;
    jump   = 1'b0;
    case (opc)
        `OP_LDA, `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_NOT, `OP_XOR, `OP_SHL, `OP_SHR:
            wr_a = 1'b1;
        `OP_LDB:   wr_b = 1'b1;
        `OP_LDAB: begin
            wr_a = 1'b1;
            wr_b = 1'b1;
        end
        `OP_STORE: wr_mem = 1'b1; // A+B into mem[imm]
        `OP_LOAD: begin
            wr_a = 1'b1;
            y    = ref_mem[dmem_idx_t'(imm)];
        end
        `OP_LDA_IMM, `OP_LDB_IMM: begin
            wr_a = (opc == `OP_LDA_IMM);
            wr_b = (opc == `OP_LDB_IMM);
            x    = '0;
            y    = imm;
        end
        `OP_JMP: jump = 1'b1;
        `OP_JZ:  jump = ref_flags[3];
        `OP_JNZ: jump = !ref_flags[3];
        `OP_JN:  jump = ref_flags[2];
        `OP_JC:  jump = ref_flags[1];
        default: ;
    endcase
    wide = (opc == `OP_SUB) ? {1'b0, x} - {1'b0, y} : {1'b0, x} + {1'b0, y};
    case (opc)
        `OP_AND: res = x & y;
        `OP_OR:  res = x | y;
        `OP_NOT: res = ~x;
        `OP_XOR: res = x ^ y;
        `OP_SHL: res = {x[6:0], 1'b0};
        `OP_SHR: res = {1'b0, x[7:1]};
        default: res = wide[`DATA_W-1:0]; // Sum, or difference for SUB
    endcase
    flg = {(res == 8'h00), res[7], wide[8], (x[7] == y[7]) && (res[7] != x[7])};
endfunction

`endif

// ==== tests/cpu_board_tb.sv ====
// Testbench for cpu_board_top with random step and mode strobes
// Model compare on LEDs and both digits, mid-run reset, watchdog
`timescale 1ns/1ps
`default_nettype none

`include "cpu_consts.svh"

module cpu_board_tb import cpu_pkg::*, disp_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    localparam int NUM_CYCLES  = 2000;
    localparam int RESET_AT    = 1200;                         // Mid-run reset cycle
    localparam int WATCHDOG_NS = 2 * NUM_CYCLES * CLK_PERIOD;

    logic    CLK;
    logic    rst;
    logic    i_step;
    logic    i_mode_next;
    nibble_t o_led;
    seg_t    o_seg_tens;
    seg_t    o_seg_ones;

    integer  seed = 81272;
    int      checks = 0;
    int      errors = 0;
    int      cyc;

    `include "cpu_model.svh"

    cpu_board_top UUT (
        .CLK         (CLK),
        .rst         (rst),
        .i_step      (i_step),
        .i_mode_next (i_mode_next),
        .o_led       (o_led),
        .o_seg_tens  (o_seg_tens),
        .o_seg_ones  (o_seg_ones)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic reset_state();
        ref_pc    = '0;
        ref_a     = '0;
        ref_b     = '0;
        ref_flags = '0;
        ref_mode  = MODE_PC;
        for (int i = 0; i < `DMEM_DEPTH; i++) ref_mem[i] = '0;
    endtask

    // One executed instruction
    task automatic step_cpu();
        data_t  res;
        flags_t flg;
        data_t  imm;
        logic   wr_a;
        logic   wr_b;
        logic   wr_mem;
        logic   jump;
        eval_instr(res, flg, imm, wr_a, wr_b, wr_mem, jump);
        ref_flags = flg; // Jumps capture flags too
        if (wr_a) ref_a = res;
        if (wr_b) ref_b = res;
        if (wr_mem) ref_mem[dmem_idx_t'(imm)] = res;
        ref_pc = jump ? imm : ref_pc + 8'd1;
    endtask

    task automatic advance_mode();
        case (ref_mode)
            MODE_PC: ref_mode = MODE_A;
            MODE_A:  ref_mode = MODE_B;
            MODE_B:  ref_mode = MODE_ALU;
            default: ref_mode = MODE_PC;
        endcase
    endtask

    // Low nibble of the selected view
    function automatic nibble_t expected_nibble();
        data_t  res;
        flags_t flg;
        data_t  imm;
        logic   wr_a;
        logic   wr_b;
        logic   wr_mem;
        logic   jump;
        eval_instr(res, flg, imm, wr_a, wr_b, wr_mem, jump);
        case (ref_mode)
            MODE_PC: return ref_pc[3:0];
            MODE_A:  return ref_a[3:0];
            MODE_B:  return ref_b[3:0];
            default: return res[3:0]; // Live ALU output
        endcase
    endfunction

    task automatic check_nibble(input string name, input nibble_t got, input nibble_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_seg(input string name, input seg_t got, input seg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_outputs();
        nibble_t nib;
        nibble_t tens;
        nibble_t ones;
        nib  = expected_nibble();
        tens = (nib >= 4'd10) ? 4'd1 : 4'd0;       // Decimal split
        ones = (nib >= 4'd10) ? nib - 4'd10 : nib;
        check_nibble("o_led", o_led, nib);
        check_seg("o_seg_tens", o_seg_tens, digit_pattern(tens));
        check_seg("o_seg_ones", o_seg_ones, digit_pattern(ones));
    endtask

    initial begin
        rst         = 1'b1;
        i_step      = 1'b0;
        i_mode_next = 1'b0;
        reset_state();
        repeat (5) @(posedge CLK);
        #1 compare_outputs(); // 0000 and "00"
        @(negedge CLK);
        rst = 1'b0;

        for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(negedge CLK);
            if (cyc == RESET_AT) begin
                rst         = 1'b1; // Async, takes effect at once
                i_step      = 1'b0;
                i_mode_next = 1'b0;
                reset_state();
                #1 compare_outputs();
                repeat (2) @(negedge CLK);
                rst = 1'b0;
            end
            i_step      = (($random(seed) & 3) != 0); // Mostly stepping
            i_mode_next = (($random(seed) & 3) == 0);
            @(posedge CLK);
            if (i_step) step_cpu();
            if (i_mode_next) advance_mode();
            #1 compare_outputs();
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Run length bound
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_board_top.f ====
+incdir+source
+incdir+tests
source/cpu_pkg.sv
source/disp_pkg.sv
source/cpu_if.sv
source/program_rom.sv
source/control_decoder.sv
source/alu.sv
source/datapath.sv
source/display_unit.sv
source/cpu_board_top.sv
tests/cpu_board_tb.sv
